/* design/fe_pkg.sv */
`default_nettype none

package fe_pkg;

  // Address and instruction widths
  localparam int VADDR_WIDTH = 32;
  localparam int INSTR_WIDTH = 32;

  // Bytes per instruction, also the sequential PC step
  localparam int INSTR_BYTES = 4;

  typedef logic [VADDR_WIDTH-1:0] pc_t;
  typedef logic [INSTR_WIDTH-1:0] instr_t;

  // Front-end command opcodes
  typedef enum logic [1:0]
  {
    e_op_pc_redirect = 2'd0,
    e_op_wait        = 2'd1
  } fe_opcode_e;

  // Fetch queue message kinds
  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_e;

  // Exception codes carried by an exception message
  typedef enum logic
  {
    e_instr_misaligned   = 1'b0,
    e_instr_access_fault = 1'b1
  } fe_exc_e;

  // Controller states
  typedef enum logic [1:0]
  {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

endpackage

`default_nettype wire

/* design/fe_pc_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fe_pc_if;

  // Current fetch PC
  fe_pkg::pc_t pc;

  // Current PC entered IF1 this cycle
  logic take;

  // Load redirect_pc next cycle, wins over take
  logic redirect_v;
  fe_pkg::pc_t redirect_pc;

  modport pc_gen
    (output pc
     , input take
     , input redirect_v
     , input redirect_pc
     );

  modport ctrl
    (output redirect_v
     , output redirect_pc
     );

  modport fetch
    (input pc
     , input redirect_v
     , output take
     );

endinterface

`default_nettype wire

/* design/fe_pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_pc_gen
  (input logic clk_i
   , input logic reset_i
   , fe_pc_if.pc_gen pc_o
   );

  fe_pkg::pc_t pc_r;
  fe_pkg::pc_t pc_n;

  // Redirect first, then sequential advance on a take
  always_comb
    begin
      pc_n = pc_r;
      if (pc_o.redirect_v)
        begin
          pc_n = pc_o.redirect_pc;
        end
      else if (pc_o.take)
        begin
          pc_n = pc_r + fe_pkg::pc_t'(fe_pkg::INSTR_BYTES);
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          pc_r <= '0;
        end
      else
        begin
          pc_r <= pc_n;
        end
    end

  assign pc_o.pc = pc_r;

endmodule

`default_nettype wire

/* design/fe_cmd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_cmd_ctrl
  (input logic clk_i
   , input logic reset_i

   , input logic fe_cmd_v_i
   , input fe_pkg::fe_opcode_e fe_cmd_opcode_i
   , input fe_pkg::pc_t fe_cmd_pc_i
   , output logic fe_cmd_yumi_o

   , output logic run_o
   , output logic flush_o

   , input logic fail_v_i
   , input fe_pkg::pc_t fail_pc_i
   , input logic exc_v_i

   , fe_pc_if.ctrl pc_o
   );

  fe_pkg::fe_state_e state_r;
  fe_pkg::fe_state_e state_n;
  fe_pkg::pc_t resume_pc_r;
  logic redirect_cmd;
  logic wait_cmd;
  logic is_stall;

  assign redirect_cmd = fe_cmd_v_i & (fe_cmd_opcode_i == fe_pkg::e_op_pc_redirect);
  assign wait_cmd     = fe_cmd_v_i & (fe_cmd_opcode_i == fe_pkg::e_op_wait);
  assign is_stall     = (state_r == fe_pkg::e_stall);

  // Commands never back up, any valid command flushes the pipe
  assign fe_cmd_yumi_o = fe_cmd_v_i;
  assign flush_o       = fe_cmd_v_i;

  always_comb
    begin
      state_n = state_r;
      case (state_r)
        fe_pkg::e_wait:
          begin
            if (redirect_cmd)
              state_n = fe_pkg::e_run;
          end
        fe_pkg::e_run:
          begin
            if (redirect_cmd)
              state_n = fe_pkg::e_run;
            // Wait goes straight to wait so nothing is replayed afterwards
            else if (wait_cmd)
              state_n = fe_pkg::e_wait;
            // Hold off until the next redirect
            else if (exc_v_i)
              state_n = fe_pkg::e_wait;
            else if (fail_v_i)
              state_n = fe_pkg::e_stall;
          end
        fe_pkg::e_stall:
          begin
            if (wait_cmd)
              state_n = fe_pkg::e_wait;
            else
              state_n = fe_pkg::e_run;
          end
        default:
          state_n = fe_pkg::e_wait;
      endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        state_r <= fe_pkg::e_wait;
      else
        state_r <= state_n;
    end

  // Replay point for a fetch the queue refused
  always_ff @(posedge clk_i)
    begin
      if (redirect_cmd)
        resume_pc_r <= fe_cmd_pc_i;
      else if (fail_v_i)
        resume_pc_r <= fail_pc_i;
    end

  // Stall leaves by restarting at the resume PC
  assign pc_o.redirect_v  = redirect_cmd | (is_stall & ~wait_cmd);
  assign pc_o.redirect_pc = redirect_cmd ? fe_cmd_pc_i : resume_pc_r;

  assign run_o = (state_n == fe_pkg::e_run);

endmodule

`default_nettype wire

/* design/fe_fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_fetch_stage
  #(parameter int IMEM_WORDS = 256)
  (input logic clk_i
   , input logic reset_i

   , fe_pc_if.fetch pc_i

   , input logic run_i
   , input logic flush_i

   , output logic imem_req_v_o
   , output fe_pkg::pc_t imem_req_addr_o
   , input logic imem_req_ready_i
   , input fe_pkg::instr_t imem_resp_data_i

   , output logic fe_queue_v_o
   , output fe_pkg::fe_msg_e fe_queue_type_o
   , output fe_pkg::pc_t fe_queue_pc_o
   , output fe_pkg::instr_t fe_queue_instr_o
   , output fe_pkg::fe_exc_e fe_queue_exc_o
   , input logic fe_queue_ready_i

   , output logic fail_v_o
   , output fe_pkg::pc_t fail_pc_o
   , output logic exc_v_o
   );

  // First byte address past the memory
  localparam fe_pkg::pc_t imem_limit = fe_pkg::pc_t'(IMEM_WORDS * fe_pkg::INSTR_BYTES);

  logic misaligned;
  logic out_of_range;
  logic fault;
  fe_pkg::fe_exc_e exc_code;
  logic can_fetch;
  logic if1_v;
  logic if2_v_r;
  logic if2_fault_r;
  fe_pkg::fe_exc_e if2_exc_r;
  fe_pkg::pc_t if2_pc_r;
  logic if2_fail;

  // IF1 fault checks on the current PC
  assign misaligned   = (pc_i.pc[1:0] != 2'b00);
  assign out_of_range = (pc_i.pc >= imem_limit);
  assign fault        = misaligned | out_of_range;
  assign exc_code     = misaligned ? fe_pkg::e_instr_misaligned : fe_pkg::e_instr_access_fault;

  // No fetch while the PC is being redirected
  assign can_fetch = run_i & ~flush_i & ~pc_i.redirect_v;

  // Faulting PCs skip memory and go straight on
  assign imem_req_v_o    = can_fetch & ~fault;
  assign imem_req_addr_o = pc_i.pc;
  assign if1_v           = can_fetch & (fault | imem_req_ready_i);
  assign pc_i.take       = if1_v;

  // Queue refused the IF2 item
  assign if2_fail = if2_v_r & ~fe_queue_ready_i & ~flush_i;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        if2_v_r <= 1'b0;
      else
        if2_v_r <= if1_v & ~if2_fail;
    end

  always_ff @(posedge clk_i)
    begin
      if (if1_v)
        begin
          if2_pc_r    <= pc_i.pc;
          if2_fault_r <= fault;
          if2_exc_r   <= exc_code;
        end
    end

  // Memory data lines up with IF2
  assign fe_queue_v_o     = if2_v_r & fe_queue_ready_i & ~flush_i;
  assign fe_queue_type_o  = if2_fault_r ? fe_pkg::e_fe_exception : fe_pkg::e_fe_fetch;
  assign fe_queue_pc_o    = if2_pc_r;
  assign fe_queue_instr_o = if2_fault_r ? '0 : imem_resp_data_i;
  assign fe_queue_exc_o   = if2_exc_r;

  assign fail_v_o  = if2_fail;
  assign fail_pc_o = if2_pc_r;
  assign exc_v_o   = fe_queue_v_o & if2_fault_r;

endmodule

`default_nettype wire

/* design/fe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_top
  #(parameter int IMEM_WORDS = 256)
  (input logic clk_i
   , input logic reset_i

   , input logic fe_cmd_v_i
   , input fe_pkg::fe_opcode_e fe_cmd_opcode_i
   , input fe_pkg::pc_t fe_cmd_pc_i
   , output logic fe_cmd_yumi_o

   , output logic imem_req_v_o
   , output fe_pkg::pc_t imem_req_addr_o
   , input logic imem_req_ready_i
   , input fe_pkg::instr_t imem_resp_data_i

   , output logic fe_queue_v_o
   , output fe_pkg::fe_msg_e fe_queue_type_o
   , output fe_pkg::pc_t fe_queue_pc_o
   , output fe_pkg::instr_t fe_queue_instr_o
   , output fe_pkg::fe_exc_e fe_queue_exc_o
   , input logic fe_queue_ready_i
   );

  logic run;
  logic flush;
  logic fail_v;
  fe_pkg::pc_t fail_pc;
  logic exc_v;

  fe_pc_if pc_if ();

  fe_pc_gen u_pc_gen
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .pc_o(pc_if.pc_gen)
     );

  fe_cmd_ctrl u_cmd_ctrl
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .fe_cmd_v_i(fe_cmd_v_i)
     , .fe_cmd_opcode_i(fe_cmd_opcode_i)
     , .fe_cmd_pc_i(fe_cmd_pc_i)
     , .fe_cmd_yumi_o(fe_cmd_yumi_o)
     , .run_o(run)
     , .flush_o(flush)
     , .fail_v_i(fail_v)
     , .fail_pc_i(fail_pc)
     , .exc_v_i(exc_v)
     , .pc_o(pc_if.ctrl)
     );

  fe_fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch_stage
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .pc_i(pc_if.fetch)
     , .run_i(run)
     , .flush_i(flush)
     , .imem_req_v_o(imem_req_v_o)
     , .imem_req_addr_o(imem_req_addr_o)
     , .imem_req_ready_i(imem_req_ready_i)
     , .imem_resp_data_i(imem_resp_data_i)
     , .fe_queue_v_o(fe_queue_v_o)
     , .fe_queue_type_o(fe_queue_type_o)
     , .fe_queue_pc_o(fe_queue_pc_o)
     , .fe_queue_instr_o(fe_queue_instr_o)
     , .fe_queue_exc_o(fe_queue_exc_o)
     , .fe_queue_ready_i(fe_queue_ready_i)
     , .fail_v_o(fail_v)
     , .fail_pc_o(fail_pc)
     , .exc_v_o(exc_v)
     );

endmodule

`default_nettype wire

/* sim/fe_ref_model.svh */
`ifndef FE_REF_MODEL_SVH
`define FE_REF_MODEL_SVH

// One expected fetch queue message
typedef struct packed
{
  fe_pkg::fe_msg_e kind;
  fe_pkg::fe_exc_e exc;
  fe_pkg::pc_t pc;
  fe_pkg::instr_t instr;
} exp_msg_t;

// Memory contents, every address bit takes part
function automatic logic [31:0] mem_word(input logic [31:0] addr);
  logic [31:0] rot;
  rot = {addr[18:0], addr[31:19]};
  return (addr * 32'h9e37_79b1) ^ rot ^ 32'h5a3c_0f96;
endfunction

// Message number index of the stream that a redirect to start_pc opens
function automatic exp_msg_t expected_msg(input logic [31:0] start_pc, input int index);
  exp_msg_t m;
  logic [31:0] pc;
  pc = start_pc + 32'(index) * 32'd4;
  m.kind = fe_pkg::e_fe_fetch;
  m.exc = fe_pkg::e_instr_misaligned;
  m.pc = pc;
  m.instr = '0;
  if (start_pc[1:0] != 2'b00)
  begin
    m.kind = fe_pkg::e_fe_exception;
    m.pc = start_pc;
  end
  else if (pc >= 32'(IMEM_WORDS * 4))
  begin
    m.kind = fe_pkg::e_fe_exception;
    m.exc = fe_pkg::e_instr_access_fault;
  end
  else
    m.instr = mem_word(pc);
  return m;
endfunction

`endif

/* sim/fe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_tb;

  localparam int IMEM_WORDS = 64;
  // Messages expected over all phases, sizes the watchdog
  localparam int TOTAL_ITEMS = 64;

  `include "fe_ref_model.svh"

  logic clk_i = 1'b0;
  logic reset_i = 1'b1;
  logic fe_cmd_v_i = 1'b0;
  fe_pkg::fe_opcode_e fe_cmd_opcode_i = fe_pkg::e_op_pc_redirect;
  fe_pkg::pc_t fe_cmd_pc_i = '0;
  logic fe_cmd_yumi_o;
  logic imem_req_v_o;
  fe_pkg::pc_t imem_req_addr_o;
  logic imem_req_ready_i = 1'b1;
  fe_pkg::instr_t imem_resp_data_i = '0;
  logic fe_queue_v_o;
  fe_pkg::fe_msg_e fe_queue_type_o;
  fe_pkg::pc_t fe_queue_pc_o;
  fe_pkg::instr_t fe_queue_instr_o;
  fe_pkg::fe_exc_e fe_queue_exc_o;
  logic fe_queue_ready_i = 1'b1;

  integer seed = 32'h61c9_0cbd;
  int errors = 0;
  int recv_cnt = 0;
  int msg_idx = 0;
  logic rand_ready = 1'b0;
  logic cmd_seen = 1'b0;
  logic stream_open = 1'b0;
  fe_pkg::pc_t start_pc = '0;
  fe_pkg::instr_t resp_next = '0;
  exp_msg_t exp_msg;

  always #4 clk_i = ~clk_i;

  fe_top #(.IMEM_WORDS(IMEM_WORDS)) u_dut
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .fe_cmd_v_i(fe_cmd_v_i)
     , .fe_cmd_opcode_i(fe_cmd_opcode_i)
     , .fe_cmd_pc_i(fe_cmd_pc_i)
     , .fe_cmd_yumi_o(fe_cmd_yumi_o)
     , .imem_req_v_o(imem_req_v_o)
     , .imem_req_addr_o(imem_req_addr_o)
     , .imem_req_ready_i(imem_req_ready_i)
     , .imem_resp_data_i(imem_resp_data_i)
     , .fe_queue_v_o(fe_queue_v_o)
     , .fe_queue_type_o(fe_queue_type_o)
     , .fe_queue_pc_o(fe_queue_pc_o)
     , .fe_queue_instr_o(fe_queue_instr_o)
     , .fe_queue_exc_o(fe_queue_exc_o)
     , .fe_queue_ready_i(fe_queue_ready_i)
     );

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string name);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Memory answers a transferred request one cycle later
  always @(posedge clk_i)
  begin
    if (imem_req_v_o && imem_req_ready_i)
      resp_next = mem_word(imem_req_addr_o);
  end

  // Collector compares each queue transfer with the reference stream
  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      check_value(32'(fe_cmd_yumi_o), 32'(fe_cmd_v_i), "fe_cmd_yumi_o");
      if (!cmd_seen)
      begin
        check_value(32'(fe_queue_v_o), 32'd0, "fe_queue_v_o");
        check_value(32'(imem_req_v_o), 32'd0, "imem_req_v_o");
      end
      if (fe_queue_v_o)
      begin
        recv_cnt++;
        if (!stream_open)
        begin
          errors++;
          $display("Unexpected fetch queue transfer at time %0t with pc %h",
                   $time, fe_queue_pc_o);
        end
        else
        begin
          exp_msg = expected_msg(start_pc, msg_idx);
          check_value(32'(fe_queue_type_o), 32'(exp_msg.kind), "fe_queue_type_o");
          check_value(fe_queue_pc_o, exp_msg.pc, "fe_queue_pc_o");
          if (exp_msg.kind == fe_pkg::e_fe_fetch)
            check_value(fe_queue_instr_o, exp_msg.instr, "fe_queue_instr_o");
          else
          begin
            check_value(32'(fe_queue_exc_o), 32'(exp_msg.exc), "fe_queue_exc_o");
            // An exception closes the stream until the next redirect
            stream_open = 1'b0;
          end
          msg_idx++;
        end
      end
      if (fe_cmd_v_i && fe_cmd_yumi_o)
      begin
        cmd_seen = 1'b1;
        start_pc = fe_cmd_pc_i;
        msg_idx = 0;
        stream_open = (fe_cmd_opcode_i == fe_pkg::e_op_pc_redirect);
      end
    end
  end

  task automatic next_cycle();
    logic [31:0] bits;
    @(negedge clk_i);
    if (rand_ready)
    begin
      bits = $random(seed);
      imem_req_ready_i = bits[0];
      fe_queue_ready_i = bits[1];
    end
    else
    begin
      imem_req_ready_i = 1'b1;
      fe_queue_ready_i = 1'b1;
    end
    imem_resp_data_i = resp_next;
    fe_cmd_v_i = 1'b0;
  endtask

  task automatic issue_cmd(input fe_pkg::fe_opcode_e op, input fe_pkg::pc_t pc);
    next_cycle();
    fe_cmd_v_i = 1'b1;
    fe_cmd_opcode_i = op;
    fe_cmd_pc_i = pc;
  endtask

  task automatic wait_msgs(input int n);
    int target;
    target = recv_cnt + n;
    while (recv_cnt < target)
      next_cycle();
  endtask

  task automatic wait_stream_end();
    next_cycle();
    while (stream_open)
      next_cycle();
  endtask

  initial
  begin
    repeat (2) @(posedge clk_i);
    next_cycle();
    reset_i = 1'b0;
    repeat (10) next_cycle();
    issue_cmd(fe_pkg::e_op_pc_redirect, 32'h0000_0040);
    wait_msgs(16);
    // Random back-pressure from here on
    rand_ready = 1'b1;
    issue_cmd(fe_pkg::e_op_pc_redirect, 32'h0000_0080);
    wait_msgs(24);
    issue_cmd(fe_pkg::e_op_pc_redirect, 32'h0000_0010);
    wait_msgs(5);
    issue_cmd(fe_pkg::e_op_pc_redirect, 32'h0000_00a0);
    wait_msgs(8);
    // Six words before the end of memory, then the access fault
    issue_cmd(fe_pkg::e_op_pc_redirect, 32'(IMEM_WORDS * 4 - 24));
    wait_stream_end();
    repeat (20) next_cycle();
    issue_cmd(fe_pkg::e_op_pc_redirect, 32'h0000_0022);
    wait_stream_end();
    repeat (20) next_cycle();
    rand_ready = 1'b0;
    issue_cmd(fe_pkg::e_op_pc_redirect, 32'h0000_0000);
    wait_msgs(3);
    issue_cmd(fe_pkg::e_op_wait, 32'h0000_0000);
    repeat (20) next_cycle();
    $display("Run complete: %0d errors, %0d messages", errors, recv_cnt);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    repeat (TOTAL_ITEMS * 40 + 200) @(posedge clk_i);
    $display("Timeout: the front end stopped delivering messages, %0d errors, %0d messages",
             errors, recv_cnt);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+sim
design/fe_pkg.sv
design/fe_pc_if.sv
design/fe_pc_gen.sv
design/fe_cmd_ctrl.sv
design/fe_fetch_stage.sv
design/fe_top.sv
sim/fe_tb.sv
